//--- hw/rv_isa_pkg.sv
// rv32i decode encodings shared by the decoder, the execute unit and the load/store unit
`default_nettype none

package rv_isa_pkg;

    // alu operation, alt bit turns add into sub and and into or
    typedef enum logic [2:0] {
        alu_none = 3'b000,
        alu_add  = 3'b001,
        alu_and  = 3'b010,
        alu_xor  = 3'b011,
        alu_shl  = 3'b100,
        alu_shr  = 3'b101,
        alu_cmp  = 3'b110,
        alu_eq   = 3'b111
    } alu_op_e;

    // alu operand pair
    typedef enum logic [1:0] {
        opnd_none    = 2'b00,
        opnd_pc_imm  = 2'b01,
        opnd_rs1_rs2 = 2'b10,
        opnd_rs1_imm = 2'b11
    } opnd_sel_e;

    // next pc source, 2'b00 left unused
    typedef enum logic [1:0] {
        pc_seq     = 2'b01,
        pc_pc_imm  = 2'b10,
        pc_rs1_imm = 2'b11
    } pc_sel_e;

    // memory operation, link writes pc+4 to rd
    typedef enum logic [2:0] {
        mem_none = 3'b000,
        mem_sb   = 3'b001,
        mem_sh   = 3'b010,
        mem_sw   = 3'b011,
        mem_link = 3'b100,
        mem_lb   = 3'b101,
        mem_lh   = 3'b110,
        mem_lw   = 3'b111
    } mem_op_e;

    // rv32i major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

endpackage

`default_nettype wire

//--- hw/core_cfg_pkg.sv
// core size and memory map constants, imported wherever widths or addresses are needed
`default_nettype none

package core_cfg_pkg;

    // data path width
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

    // data memory window
    localparam int              dmem_words = 256;
    localparam int              dmem_aw    = $clog2(dmem_words);
    localparam logic [xlen-1:0] dmem_base  = 32'h8000_1000;

endpackage

`default_nettype wire

//--- hw/ctrl_if.sv
// decoded instruction bundle, driven by the decoder and read by regfile, exu and lsu
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    // register indices and immediate
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    // reg_ren is {rs2, rs1}
    logic                  reg_wen;
    logic [1:0]            reg_ren;
    opnd_sel_e             opnd_sel;
    alu_op_e               alu_op;
    pc_sel_e               pc_sel;
    mem_op_e               mem_op;
    // modifiers
    logic                  alt;
    logic                  signed_en;
    logic                  invert;
    logic                  halt_req;

    modport dec (
        output rs1, rs2, rd, imm, reg_wen, reg_ren, opnd_sel, alu_op, pc_sel,
               mem_op, alt, signed_en, invert, halt_req
    );

    modport sink (
        input rs1, rs2, rd, imm, reg_wen, reg_ren, opnd_sel, alu_op, pc_sel,
              mem_op, alt, signed_en, invert, halt_req
    );

endinterface

`default_nettype wire

//--- hw/idu.sv
// rv32i instruction decoder that turns the fetched word into control fields on ctrl_if
`timescale 1ns/1ps
`default_nettype none

module idu (
    input  logic [core_cfg_pkg::xlen-1:0] inst,
    ctrl_if.dec                           ctrl
);
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];

    // index fields sit at fixed positions in every format
    assign ctrl.rd  = inst[11:7];
    assign ctrl.rs1 = inst[19:15];
    assign ctrl.rs2 = inst[24:20];

    always_comb begin
        // unsupported opcodes fall through as a no-op
        ctrl.imm       = {{20{inst[31]}}, inst[31:20]};
        ctrl.reg_wen   = 1'b0;
        ctrl.reg_ren   = 2'b00;
        ctrl.opnd_sel  = opnd_none;
        ctrl.alu_op    = alu_none;
        ctrl.pc_sel    = pc_seq;
        ctrl.mem_op    = mem_none;
        ctrl.alt       = 1'b0;
        ctrl.signed_en = 1'b0;
        ctrl.invert    = 1'b0;
        ctrl.halt_req  = 1'b0;
        case (opcode)
            opc_lui: begin
                // rs1 read disabled so the alu sees 0 + imm
                ctrl.imm      = {inst[31:12], 12'b0};
                ctrl.reg_wen  = 1'b1;
                ctrl.opnd_sel = opnd_rs1_imm;
                ctrl.alu_op   = alu_add;
            end
            opc_auipc: begin
                ctrl.imm      = {inst[31:12], 12'b0};
                ctrl.reg_wen  = 1'b1;
                ctrl.opnd_sel = opnd_pc_imm;
                ctrl.alu_op   = alu_add;
            end
            opc_jal: begin
                ctrl.imm     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                ctrl.reg_wen = 1'b1;
                ctrl.pc_sel  = pc_pc_imm;
                ctrl.mem_op  = mem_link;
            end
            opc_jalr: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.reg_ren  = 2'b01;
                ctrl.opnd_sel = opnd_rs1_imm;
                ctrl.alu_op   = alu_add;
                ctrl.pc_sel   = pc_rs1_imm;
                ctrl.mem_op   = mem_link;
            end
            opc_branch: begin
                ctrl.imm       = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                ctrl.reg_ren   = 2'b11;
                ctrl.opnd_sel  = opnd_rs1_rs2;
                ctrl.pc_sel    = pc_pc_imm;
                // beq/bne use eq and the rest use lt
                // odd funct3 flips the result
                ctrl.alu_op    = funct3[2] ? alu_cmp : alu_eq;
                ctrl.invert    = funct3[0];
                ctrl.signed_en = ~funct3[1];
            end
            opc_load: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_ren   = 2'b01;
                ctrl.opnd_sel  = opnd_rs1_imm;
                ctrl.alu_op    = alu_add;
                ctrl.signed_en = ~funct3[2];
                case (funct3[1:0])
                    2'b00:   ctrl.mem_op = mem_lb;
                    2'b01:   ctrl.mem_op = mem_lh;
                    default: ctrl.mem_op = mem_lw;
                endcase
            end
            opc_store: begin
                ctrl.imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                ctrl.reg_ren  = 2'b11;
                ctrl.opnd_sel = opnd_rs1_imm;
                ctrl.alu_op   = alu_add;
                case (funct3[1:0])
                    2'b00:   ctrl.mem_op = mem_sb;
                    2'b01:   ctrl.mem_op = mem_sh;
                    default: ctrl.mem_op = mem_sw;
                endcase
            end
            opc_op, opc_op_imm: begin
                ctrl.reg_wen  = 1'b1;
                ctrl.reg_ren  = (opcode == opc_op) ? 2'b11 : 2'b01;
                ctrl.opnd_sel = (opcode == opc_op) ? opnd_rs1_rs2 : opnd_rs1_imm;
                case (funct3)
                    3'b000: begin
                        // sub only exists in the register form
                        ctrl.alu_op = alu_add;
                        ctrl.alt    = (opcode == opc_op) && funct7_5;
                    end
                    3'b001: ctrl.alu_op = alu_shl;
                    3'b010: begin
                        ctrl.alu_op    = alu_cmp;
                        ctrl.signed_en = 1'b1;
                    end
                    3'b011: ctrl.alu_op = alu_cmp;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b101: begin
                        ctrl.alu_op    = alu_shr;
                        ctrl.signed_en = funct7_5;
                    end
                    3'b110: begin
                        ctrl.alu_op = alu_and;
                        ctrl.alt    = 1'b1;
                    end
                    default: ctrl.alu_op = alu_and;
                endcase
            end
            opc_system: begin
                // only ebreak decoded
                // ecall and csr ops act as no-ops
                ctrl.halt_req = (inst[31:7] == {12'h001, 13'h0});
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
// 32 x xlen register file, two combinational reads and one write per clock
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wen,
    ctrl_if.sink                          ctrl,
    input  logic [core_cfg_pkg::xlen-1:0] wdata,
    output logic [core_cfg_pkg::xlen-1:0] rs1_data,
    output logic [core_cfg_pkg::xlen-1:0] rs2_data
);
    import core_cfg_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:reg_count-1];

    // disabled or x0 reads give zero
    assign rs1_data = (ctrl.reg_ren[0] && ctrl.rs1 != '0) ? regs[ctrl.rs1] : '0;
    assign rs2_data = (ctrl.reg_ren[1] && ctrl.rs2 != '0) ? regs[ctrl.rs2] : '0;

    always_ff @(posedge clk) begin
        // no writes while in reset, writes to x0 dropped
        if (rst_n && wen && ctrl.rd != '0) begin
            regs[ctrl.rd] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/exu.sv
// execute unit: operand select, alu, branch compare and next pc
`timescale 1ns/1ps
`default_nettype none

module exu (
    ctrl_if.sink                          ctrl,
    input  logic [core_cfg_pkg::xlen-1:0] pc,
    input  logic [core_cfg_pkg::xlen-1:0] rs1_data,
    input  logic [core_cfg_pkg::xlen-1:0] rs2_data,
    output logic [core_cfg_pkg::xlen-1:0] alu_res,
    output logic [core_cfg_pkg::xlen-1:0] dnpc
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [4:0]      shamt;
    logic            lt;
    logic            take;

    always_comb begin
        case (ctrl.opnd_sel)
            opnd_pc_imm:  begin opa = pc;       opb = ctrl.imm; end
            opnd_rs1_rs2: begin opa = rs1_data; opb = rs2_data; end
            opnd_rs1_imm: begin opa = rs1_data; opb = ctrl.imm; end
            default:      begin opa = '0;       opb = '0;       end
        endcase
    end

    assign shamt = opb[4:0];
    // slt/sltu and blt/bge/bltu/bgeu share this compare
    assign lt    = ctrl.signed_en ? ($signed(opa) < $signed(opb)) : (opa < opb);

    always_comb begin
        alu_res = '0;
        case (ctrl.alu_op)
            alu_add: alu_res = ctrl.alt ? opa - opb : opa + opb;
            alu_and: alu_res = ctrl.alt ? opa | opb : opa & opb;
            alu_xor: alu_res = opa ^ opb;
            alu_shl: alu_res = opa << shamt;
            alu_shr: begin
                // kept apart so sra stays arithmetic
                if (ctrl.signed_en) begin
                    alu_res = $signed(opa) >>> shamt;
                end else begin
                    alu_res = opa >> shamt;
                end
            end
            alu_cmp: alu_res = {{(xlen-1){1'b0}}, lt};
            alu_eq:  alu_res = {{(xlen-1){1'b0}}, opa == opb};
            default: ;
        endcase
    end

    // jal always takes pc+imm, branches only on a true compare
    assign take = (ctrl.alu_op == alu_cmp || ctrl.alu_op == alu_eq) ?
                  (alu_res[0] ^ ctrl.invert) : 1'b1;

    always_comb begin
        case (ctrl.pc_sel)
            pc_pc_imm:  dnpc = take ? pc + ctrl.imm : pc + 'd4;
            // jalr target with bit 0 cleared
            pc_rs1_imm: dnpc = {alu_res[xlen-1:1], 1'b0};
            default:    dnpc = pc + 'd4;
        endcase
    end

    // once pc is known the decoder must give a defined alu op
    always_comb begin
        assert final ($isunknown(pc) || !$isunknown(ctrl.alu_op));
    end

endmodule

`default_nettype wire

//--- hw/lsu.sv
// load/store unit with word-wide data memory, also picks the value written back to rd
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          halted,
    ctrl_if.sink                          ctrl,
    input  logic [core_cfg_pkg::xlen-1:0] pc,
    input  logic [core_cfg_pkg::xlen-1:0] addr,
    input  logic [core_cfg_pkg::xlen-1:0] store_data,
    output logic [core_cfg_pkg::xlen-1:0] wb_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [xlen-1:0]    mem [dmem_words];
    logic [xlen-1:0]    offs;
    logic [dmem_aw-1:0] widx;
    logic [1:0]         boff;
    logic [xlen-1:0]    rword;
    logic [xlen-1:0]    lane;
    logic               is_mem;
    logic               misaligned;

    // offset into the data window
    assign offs  = addr - dmem_base;
    assign widx  = offs[dmem_aw+1:2];
    assign boff  = offs[1:0];
    assign rword = mem[widx];
    // addressed byte or half moved down to bit 0
    assign lane  = rword >> {boff, 3'b000};

    always_ff @(posedge clk) begin
        if (rst_n && !halted) begin
            case (ctrl.mem_op)
                mem_sb:  mem[widx][{boff, 3'b000} +: 8] <= store_data[7:0];
                mem_sh:  mem[widx][{boff[1], 4'b0000} +: 16] <= store_data[15:0];
                mem_sw:  mem[widx] <= store_data;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (ctrl.mem_op)
            mem_lb:   wb_data = {{24{ctrl.signed_en & lane[7]}}, lane[7:0]};
            mem_lh:   wb_data = {{16{ctrl.signed_en & lane[15]}}, lane[15:0]};
            mem_lw:   wb_data = rword;
            // jal/jalr return address
            mem_link: wb_data = pc + 'd4;
            default:  wb_data = addr;
        endcase
    end

    assign is_mem     = ctrl.mem_op inside {mem_sb, mem_sh, mem_sw, mem_lb, mem_lh, mem_lw};
    assign misaligned = ((ctrl.mem_op == mem_sh || ctrl.mem_op == mem_lh) && boff[0]) ||
                        ((ctrl.mem_op == mem_sw || ctrl.mem_op == mem_lw) && boff != 2'b00);

    // address from exu must fit the window and the access width
    ap_dmem_access: assert property (@(posedge clk) disable iff (!rst_n)
        (is_mem && !halted) |-> ((offs >> 2) < dmem_words && !misaligned));

endmodule

`default_nettype wire

//--- hw/core_top.sv
// single-cycle rv32i core top with the fetch port to the environment and a write-back trace
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                                clk,
    input  logic                                rst_n,
    output logic [core_cfg_pkg::xlen-1:0]       pc,
    input  logic [core_cfg_pkg::xlen-1:0]       inst,
    output logic                                halted,
    output logic                                wb_en,
    output logic [core_cfg_pkg::reg_addr_w-1:0] wb_addr,
    output logic [core_cfg_pkg::xlen-1:0]       wb_data
);
    import core_cfg_pkg::*;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] dnpc;

    ctrl_if ctrl ();

    idu u_idu (.inst(inst), .ctrl(ctrl.dec));

    // trace mirrors the regfile write port
    assign wb_en   = ctrl.reg_wen && rst_n && !halted;
    assign wb_addr = ctrl.rd;

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wen      (wb_en),
        .ctrl     (ctrl.sink),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exu u_exu (
        .ctrl     (ctrl.sink),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .alu_res  (alu_res),
        .dnpc     (dnpc)
    );

    lsu u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .halted     (halted),
        .ctrl       (ctrl.sink),
        .pc         (pc),
        .addr       (alu_res),
        .store_data (rs2_data),
        .wb_data    (wb_data)
    );

    // ebreak freezes the pc on itself
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= reset_vector;
            halted <= 1'b0;
        end else if (!halted) begin
            pc     <= ctrl.halt_req ? pc : dnpc;
            halted <= ctrl.halt_req;
        end
    end

    // jumps and branches must keep the pc word aligned
    ap_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verif/rv_ref_model.svh
// rv32i instruction-set reference model, included inside the testbench module body
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// major opcodes of the rv32i base encoding
localparam logic [6:0]  opc_lui    = 7'b0110111;
localparam logic [6:0]  opc_auipc  = 7'b0010111;
localparam logic [6:0]  opc_jal    = 7'b1101111;
localparam logic [6:0]  opc_jalr   = 7'b1100111;
localparam logic [6:0]  opc_branch = 7'b1100011;
localparam logic [6:0]  opc_load   = 7'b0000011;
localparam logic [6:0]  opc_store  = 7'b0100011;
localparam logic [6:0]  opc_op_imm = 7'b0010011;
localparam logic [6:0]  opc_op     = 7'b0110011;
localparam logic [31:0] ebreak_word = 32'h0010_0073;

// one instruction on m_regs, m_bytes, m_pc and m_halted
// returns the expected register write of that instruction
function automatic void ref_step(
    input  logic [31:0] ins,
    output logic        e_wen,
    output logic [4:0]  e_rd,
    output logic [31:0] e_val
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] nxt;
    logic [31:0] ld;
    logic        taken;
    int          off;
    int          k;
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    nxt   = m_pc + 32'd4;
    e_wen = 1'b0;
    e_rd  = ins[11:7];
    e_val = '0;
    taken = 1'b0;
    // halted core retires nothing
    if (!m_halted) begin
        case (ins[6:0])
            opc_lui: begin
                e_wen = 1'b1;
                e_val = {ins[31:12], 12'b0};
            end
            opc_auipc: begin
                e_wen = 1'b1;
                e_val = m_pc + {ins[31:12], 12'b0};
            end
            opc_jal: begin
                e_wen = 1'b1;
                e_val = m_pc + 32'd4;
                nxt   = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            opc_jalr: begin
                e_wen = 1'b1;
                e_val = m_pc + 32'd4;
                // target lsb always dropped
                nxt   = (a + imm_i) & ~32'd1;
            end
            opc_branch: begin
                case (ins[14:12])
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    nxt = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            opc_load: begin
                off   = a + imm_i - dmem_base;
                // little endian, upper bytes unused for narrow loads
                ld    = {m_bytes[off + 3], m_bytes[off + 2], m_bytes[off + 1], m_bytes[off]};
                e_wen = 1'b1;
                case (ins[14:12])
                    3'd0:    e_val = {{24{ld[7]}}, ld[7:0]};
                    3'd1:    e_val = {{16{ld[15]}}, ld[15:0]};
                    3'd4:    e_val = {24'b0, ld[7:0]};
                    3'd5:    e_val = {16'b0, ld[15:0]};
                    default: e_val = ld;
                endcase
            end
            opc_store: begin
                off = a + {{20{ins[31]}}, ins[31:25], ins[11:7]} - dmem_base;
                for (k = 0; k < (1 << ins[13:12]); k++) begin
                    m_bytes[off + k] = b[8*k +: 8];
                end
            end
            opc_op, opc_op_imm: begin
                if (ins[6:0] == opc_op_imm) begin
                    b = imm_i;
                end
                e_wen = 1'b1;
                case (ins[14:12])
                    3'd0:    e_val = (ins[6:0] == opc_op && ins[30]) ? a - b : a + b;
                    3'd1:    e_val = a << b[4:0];
                    3'd2:    e_val = {31'b0, $signed(a) < $signed(b)};
                    3'd3:    e_val = {31'b0, a < b};
                    3'd4:    e_val = a ^ b;
                    3'd5: begin
                        if (ins[30]) begin
                            e_val = $signed(a) >>> b[4:0];
                        end else begin
                            e_val = a >> b[4:0];
                        end
                    end
                    3'd6:    e_val = a | b;
                    default: e_val = a & b;
                endcase
            end
            default: begin
                // ebreak parks the pc on itself
                if (ins == ebreak_word) begin
                    m_halted = 1'b1;
                    nxt      = m_pc;
                end
            end
        endcase
        if (e_wen && e_rd != 5'd0) begin
            m_regs[e_rd] = e_val;
        end
        m_pc = nxt;
    end
endfunction

`endif

//--- verif/tb_core_top.sv
// testbench for core_top that runs a generated rv32i program and checks every retired instruction
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
    import core_cfg_pkg::*;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        halted;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // model state stepped by ref_step
    logic [31:0] m_regs [0:31];
    logic [7:0]  m_bytes [0:dmem_words*4-1];
    logic [31:0] m_pc;
    logic        m_halted;

    // program store that answers the fetch port
    logic [31:0] imem [0:511];
    int          prog_len;

    logic        e_wen;
    logic [4:0]  e_rd;
    logic [31:0] e_val;
    int          check_count;
    int          err_count;
    int          timeout_count;

    `include "rv_ref_model.svh"

    core_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (pc),
        .inst    (inst),
        .halted  (halted),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - reset_vector) >> 2;
        // past the program or unknown pc reads as ebreak
        if (idx < prog_len) begin
            return imem[idx];
        end else begin
            return ebreak_word;
        end
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        return $urandom % n;
    endfunction

    // rv32i instruction formats
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // addi into x1..x29 for a branch to skip
    task automatic emit_filler();
        emit(enc_i(pick(4096), pick(32), 3'd0, 1 + pick(29), opc_op_imm));
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            err_count++;
            $display("error at %0t: %s mismatch, got %h expected %h", $time, what, got,
                     expected);
        end
    endtask

    task automatic build_program();
        int         i;
        int         k;
        int         kind;
        int         skip;
        logic [4:0] rd;
        logic [4:0] r1;
        logic [4:0] r2;
        logic [2:0] f3;
        logic [1:0] w;
        prog_len = 0;
        // every register gets a value before it is read
        for (k = 1; k < 32; k++) begin
            emit(enc_i(pick(4096), 5'd0, 3'd0, k, opc_op_imm));
        end
        // alu mix with x30 and x31 kept out of rd
        for (i = 0; i < 60; i++) begin
            kind = pick(6);
            rd   = pick(30);
            r1   = pick(32);
            r2   = pick(32);
            f3   = pick(8);
            if (kind < 2) begin
                emit(enc_r(((f3 == 0 || f3 == 5) && pick(2) == 1) ? 7'h20 : 7'h00,
                           r2, r1, f3, rd));
            end else if (kind < 4 && (f3 == 1 || f3 == 5)) begin
                // r2 doubles as shamt for shift immediates
                emit(enc_i({(f3 == 5 && pick(2) == 1) ? 7'h20 : 7'h00, r2}, r1, f3, rd,
                           opc_op_imm));
            end else if (kind < 4) begin
                emit(enc_i(pick(4096), r1, f3, rd, opc_op_imm));
            end else if (kind == 4) begin
                emit(enc_u(pick(1 << 20), rd, opc_lui));
            end else begin
                emit(enc_u(pick(1 << 20), rd, opc_auipc));
            end
        end
        // forward-only control flow
        for (i = 0; i < 30; i++) begin
            kind = pick(5);
            rd   = pick(30);
            if (kind == 0) begin
                emit(enc_j(21'd8, rd));
                emit_filler();
            end else if (kind == 1) begin
                // odd offset half the time so the lsb gets cleared
                emit(enc_u(20'd0, 5'd30, opc_auipc));
                emit(enc_i(12 + pick(2), 5'd30, 3'd0, rd, opc_jalr));
                emit_filler();
            end else begin
                f3 = pick(6);
                if (f3 >= 2) begin
                    f3 = f3 + 3'd2;
                end
                r1   = pick(32);
                r2   = (pick(4) == 0) ? r1 : pick(32);
                skip = 1 + pick(2);
                emit(enc_b((skip + 1) * 4, r2, r1, f3));
                for (k = 0; k < skip; k++) begin
                    emit_filler();
                end
            end
        end
        // x31 points at the data window
        emit(enc_u(dmem_base[31:12], 5'd31, opc_lui));
        for (k = 0; k < 16; k++) begin
            emit(enc_s(k * 4, pick(32), 5'd31, 3'd2));
        end
        // narrow stores and loads inside the words written above
        for (i = 0; i < 40; i++) begin
            w = pick(3);
            if (pick(2) == 1) begin
                emit(enc_s(pick(64 >> w) << w, pick(32), 5'd31, {1'b0, w}));
            end else begin
                f3 = (w != 2'd2 && pick(2) == 1) ? {1'b1, w} : {1'b0, w};
                emit(enc_i(pick(64 >> w) << w, 5'd31, f3, 1 + pick(29), opc_load));
            end
        end
        emit(ebreak_word);
    endtask

    task automatic wait_for_halt(input int limit);
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            timeout_count++;
            $display("timeout: core did not halt within %0d cycles", limit);
        end
    endtask

    // frozen pc and no write-back while a writing instruction sits on the fetch port
    task automatic hold_after_halt(input int cycles);
        int          i;
        logic [31:0] halt_pc;
        halt_pc = pc;
        // addi x5, x0, 0x123 in place of the ebreak under the frozen pc
        imem[prog_len - 1] = enc_i(12'h123, 5'd0, 3'd0, 5'd5, opc_op_imm);
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("halted after ebreak", halted, 1'b1);
            check_value("pc after ebreak", pc, halt_pc);
            check_value("wb_en after ebreak", wb_en, 1'b0);
        end
    endtask

    // fetch answers the pc held since the last rising edge
    always @(negedge clk) begin
        inst <= fetch_word(pc);
    end

    // model retires alongside the core on each rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            check_value("wb_en during reset", wb_en, 1'b0);
            m_pc     = reset_vector;
            m_halted = 1'b0;
        end else begin
            check_value("pc", pc, m_pc);
            check_value("halted", halted, m_halted);
            ref_step(fetch_word(m_pc), e_wen, e_rd, e_val);
            check_value("wb_en", wb_en, e_wen);
            if (e_wen) begin
                check_value("wb_addr", wb_addr, e_rd);
                check_value("wb_data", wb_data, e_val);
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        inst          = 32'h0000_0013;
        check_count   = 0;
        err_count     = 0;
        timeout_count = 0;
        m_pc          = reset_vector;
        m_halted      = 1'b0;
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        void'($urandom(30));
        build_program();
        repeat (10) @(negedge clk);
        check_value("pc in reset", pc, reset_vector);
        check_value("wb_en in reset", wb_en, 1'b0);
        rst_n = 1'b1;
        wait_for_halt(2000);
        if (timeout_count == 0) begin
            hold_after_halt(8);
        end
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count,
                 timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verif
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/ctrl_if.sv
hw/idu.sv
hw/regfile.sv
hw/exu.sv
hw/lsu.sv
hw/core_top.sv
verif/tb_core_top.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - hw/rv_isa_pkg.sv
  - hw/core_cfg_pkg.sv
  - hw/ctrl_if.sv
  - hw/idu.sv
  - hw/regfile.sv
  - hw/exu.sv
  - hw/lsu.sv
  - hw/core_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_core_top.sv
